/* design/mmio_defines.svh */
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// Data and address width.
`define MMIO_XLEN 32

// Device registers.
`define MMIO_ADDR_UART_TX 32'hFF00_0000
`define MMIO_ADDR_UART_RX 32'hFF00_0004

// Timer window: mtime lo/hi, mtimecmp lo/hi.
`define MMIO_CLINT_BASE 32'hFF00_0010
`define MMIO_CLINT_END  32'hFF00_001F

// Data RAM depth in words.
`define MMIO_RAM_WORDS 256

// Short bit period so frames stay cheap in simulation.
`define MMIO_UART_CLKS_PER_BIT 8

`endif

/* design/mmio_pkg.sv */
`default_nettype none
`include "mmio_defines.svh"

package mmio_pkg;

    typedef logic [`MMIO_XLEN-1:0]   word_t;
    typedef logic [2*`MMIO_XLEN-1:0] dword_t;
    typedef logic [`MMIO_XLEN/8-1:0] wmask_t;

    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_UART_TX,
        TGT_UART_RX,
        TGT_CLINT
    } mmio_target_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_WAIT_READY,
        CTRL_READ_VALID
    } ctrl_state_e;

    // Serial bit phase, used by both UART directions.
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    function automatic word_t apply_wmask(word_t old_word, word_t new_word, wmask_t mask);
        word_t res;
        res = old_word;
        for (int b = 0; b < `MMIO_XLEN / 8; b++) begin
            if (mask[b]) res[8*b +: 8] = new_word[8*b +: 8];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

/* design/dbus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dbus_if import mmio_pkg::*; ();

    logic   req_valid;
    logic   req_ready;
    word_t  req_addr;
    logic   req_wen;
    word_t  req_wdata;
    wmask_t req_wmask;

    // Read data only, writes get no response.
    logic   resp_valid;
    word_t  resp_rdata;

    modport host (
        output req_valid, req_addr, req_wen, req_wdata, req_wmask,
        input  req_ready, resp_valid, resp_rdata
    );

    modport device (
        input  req_valid, req_addr, req_wen, req_wdata, req_wmask,
        output req_ready, resp_valid, resp_rdata
    );

endinterface

`default_nettype wire

/* design/mmio_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module mmio_ctrl import mmio_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         req_valid,
    output logic        req_ready,
    input  wire word_t  req_addr,
    input  wire         req_wen,
    input  wire word_t  req_wdata,
    input  wire wmask_t req_wmask,
    output logic        resp_valid,
    output word_t       resp_addr,
    output word_t       resp_rdata,
    dbus_if.host        mem_bus,
    dbus_if.host        utx_bus,
    dbus_if.host        urx_bus,
    dbus_if.host        clint_bus
);

    ctrl_state_e  state;
    ctrl_state_e  state_nxt;
    logic         lat_valid;
    word_t        lat_addr;
    logic         lat_wen;
    word_t        lat_wdata;
    wmask_t       lat_wmask;
    mmio_target_e lat_tgt;

    logic         take_new;
    logic         rsp_fire;
    logic         fwd_valid;
    word_t        cur_addr;
    logic         cur_wen;
    word_t        cur_wdata;
    wmask_t       cur_wmask;
    mmio_target_e cur_tgt;
    logic         tgt_ready;
    logic         sel_resp_valid;
    word_t        sel_rdata;

    function automatic mmio_target_e decode(word_t a);
        if (a == `MMIO_ADDR_UART_TX) return TGT_UART_TX;
        if (a == `MMIO_ADDR_UART_RX) return TGT_UART_RX;
        if (a >= `MMIO_CLINT_BASE && a <= `MMIO_CLINT_END) return TGT_CLINT;
        return TGT_MEM;
    endfunction

    // Pending read completes this cycle.
    assign rsp_fire = state == CTRL_READ_VALID && lat_valid && sel_resp_valid;
    assign take_new = state == CTRL_IDLE || rsp_fire;  // Back-to-back with response.

    assign req_ready  = take_new;
    assign resp_valid = rsp_fire;
    assign resp_addr  = lat_addr;
    assign resp_rdata = sel_rdata;

    // Live request when accepting, latched copy while waiting.
    assign cur_addr  = take_new ? req_addr  : lat_addr;
    assign cur_wen   = take_new ? req_wen   : lat_wen;
    assign cur_wdata = take_new ? req_wdata : lat_wdata;
    assign cur_wmask = take_new ? req_wmask : lat_wmask;
    assign cur_tgt   = take_new ? decode(req_addr) : lat_tgt;
    assign fwd_valid = take_new ? req_valid : (state == CTRL_WAIT_READY);

    assign mem_bus.req_valid   = fwd_valid && cur_tgt == TGT_MEM;
    assign utx_bus.req_valid   = fwd_valid && cur_tgt == TGT_UART_TX;
    assign urx_bus.req_valid   = fwd_valid && cur_tgt == TGT_UART_RX;
    assign clint_bus.req_valid = fwd_valid && cur_tgt == TGT_CLINT;

    assign mem_bus.req_addr    = cur_addr;
    assign utx_bus.req_addr    = cur_addr;
    assign urx_bus.req_addr    = cur_addr;
    assign clint_bus.req_addr  = cur_addr;
    assign mem_bus.req_wen     = cur_wen;
    assign utx_bus.req_wen     = cur_wen;
    assign urx_bus.req_wen     = cur_wen;
    assign clint_bus.req_wen   = cur_wen;
    assign mem_bus.req_wdata   = cur_wdata;
    assign utx_bus.req_wdata   = cur_wdata;
    assign urx_bus.req_wdata   = cur_wdata;
    assign clint_bus.req_wdata = cur_wdata;
    assign mem_bus.req_wmask   = cur_wmask;
    assign utx_bus.req_wmask   = cur_wmask;
    assign urx_bus.req_wmask   = cur_wmask;
    assign clint_bus.req_wmask = cur_wmask;

    always_comb begin
        case (cur_tgt)
            TGT_UART_TX: tgt_ready = utx_bus.req_ready;
            TGT_UART_RX: tgt_ready = urx_bus.req_ready;
            TGT_CLINT:   tgt_ready = clint_bus.req_ready;
            default:     tgt_ready = mem_bus.req_ready;
        endcase
    end

    // Response follows the latched target.
    always_comb begin
        case (lat_tgt)
            TGT_UART_TX: begin
                sel_resp_valid = utx_bus.resp_valid;
                sel_rdata      = utx_bus.resp_rdata;
            end
            TGT_UART_RX: begin
                sel_resp_valid = urx_bus.resp_valid;
                sel_rdata      = urx_bus.resp_rdata;
            end
            TGT_CLINT: begin
                sel_resp_valid = clint_bus.resp_valid;
                sel_rdata      = clint_bus.resp_rdata;
            end
            default: begin
                sel_resp_valid = mem_bus.resp_valid;
                sel_rdata      = mem_bus.resp_rdata;
            end
        endcase
    end

    always_comb begin
        state_nxt = state;
        if (take_new) begin
            if (!req_valid) state_nxt = CTRL_IDLE;
            else if (!tgt_ready) state_nxt = CTRL_WAIT_READY;
            else state_nxt = req_wen ? CTRL_IDLE : CTRL_READ_VALID;
        end else if (state == CTRL_WAIT_READY && tgt_ready) begin
            state_nxt = lat_wen ? CTRL_IDLE : CTRL_READ_VALID;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= CTRL_IDLE;
            lat_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            lat_valid <= state_nxt != CTRL_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (take_new && req_valid) begin
            lat_addr  <= req_addr;
            lat_wen   <= req_wen;
            lat_wdata <= req_wdata;
            lat_wmask <= req_wmask;
            lat_tgt   <= cur_tgt;
        end
    end

    a_one_target: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({mem_bus.resp_valid, utx_bus.resp_valid, urx_bus.resp_valid,
                  clint_bus.resp_valid}));

    // Targets answer only a read the controller is waiting on.
    a_resp_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_bus.resp_valid || utx_bus.resp_valid || urx_bus.resp_valid ||
         clint_bus.resp_valid) |-> state == CTRL_READ_VALID);

    // A stalled target sees the same request next cycle.
    a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fwd_valid && !tgt_ready |=>
            fwd_valid && $stable({cur_addr, cur_wen, cur_wdata, cur_wmask, cur_tgt}));

endmodule

`default_nettype wire

/* design/uart_tx_dev.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module uart_tx_dev import mmio_pkg::*; #(
    parameter int clks_per_bit = `MMIO_UART_CLKS_PER_BIT
) (
    input  wire    clk,
    input  wire    rst_n,
    dbus_if.device bus,
    output logic   uart_tx
);

    localparam int CNT_W = $clog2(clks_per_bit + 1);

    uart_state_e      state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic             busy;
    logic             bit_end;
    logic             frame_start;

    assign busy        = state != UART_IDLE;
    assign bit_end     = clk_cnt == CNT_W'(clks_per_bit - 1);
    assign bus.req_ready = !(busy && bus.req_wen);  // Status reads pass during a frame.
    assign frame_start = bus.req_valid && bus.req_ready && bus.req_wen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= (state == UART_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                UART_IDLE:  if (frame_start) state <= UART_START;
                UART_START: if (bit_end) state <= UART_DATA;
                UART_DATA: if (bit_end) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= UART_STOP;
                end
                UART_STOP:  if (bit_end) state <= UART_IDLE;
                default:    state <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start) shift_q <= bus.req_wdata[7:0];
        else if (state == UART_DATA && bit_end) shift_q <= {1'b0, shift_q[7:1]};  // LSB first.
    end

    always_comb begin
        case (state)
            UART_START: uart_tx = 1'b0;
            UART_DATA:  uart_tx = shift_q[0];
            default:    uart_tx = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) bus.resp_valid <= 1'b0;
        else bus.resp_valid <= bus.req_valid && bus.req_ready && !bus.req_wen;
    end

    always_ff @(posedge clk) bus.resp_rdata <= word_t'(busy);

    // Start, eight data bits and stop.
    a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |-> ##(10 * clks_per_bit) $fell(busy));

endmodule

`default_nettype wire

/* design/uart_rx_dev.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module uart_rx_dev import mmio_pkg::*; #(
    parameter int clks_per_bit = `MMIO_UART_CLKS_PER_BIT
) (
    input  wire    clk,
    input  wire    rst_n,
    dbus_if.device bus,
    input  wire    uart_rx
);

    localparam int CNT_W = $clog2(clks_per_bit + 1);
    localparam int HALF  = clks_per_bit / 2;

    uart_state_e      state;
    logic             rx_s1;
    logic             rx_s2;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;
    logic [7:0]       hold_q;
    logic             full_q;
    logic             sample;
    logic             byte_done;
    logic             rd_fire;

    // Half a bit into the start bit, then one full period per bit.
    assign sample = (state == UART_START) ? clk_cnt == CNT_W'(HALF - 1)
                                          : clk_cnt == CNT_W'(clks_per_bit - 1);
    assign byte_done = state == UART_STOP && sample && rx_s2;  // Needs a valid stop bit.
    assign rd_fire   = bus.req_valid && !bus.req_wen;

    assign bus.req_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_s1   <= 1'b1;
            rx_s2   <= 1'b1;
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            rx_s1   <= uart_rx;
            rx_s2   <= rx_s1;
            clk_cnt <= (state == UART_IDLE || sample) ? '0 : clk_cnt + 1'b1;
            case (state)
                UART_IDLE:  if (!rx_s2) state <= UART_START;
                UART_START: if (sample) state <= rx_s2 ? UART_IDLE : UART_DATA;  // Glitch.
                UART_DATA: if (sample) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= UART_STOP;
                end
                UART_STOP:  if (sample) state <= UART_IDLE;
                default:    state <= UART_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == UART_DATA && sample) shift_q <= {rx_s2, shift_q[7:1]};
        if (byte_done) hold_q <= shift_q;
    end

    // New byte wins over a read in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) full_q <= 1'b0;
        else if (byte_done) full_q <= 1'b1;
        else if (rd_fire) full_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) bus.resp_valid <= 1'b0;
        else bus.resp_valid <= rd_fire;
    end

    always_ff @(posedge clk) bus.resp_rdata <= word_t'({full_q, hold_q});

endmodule

`default_nettype wire

/* design/clint_dev.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_dev import mmio_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    dbus_if.device bus,
    output logic   timer_irq
);

    dword_t     mtime;
    dword_t     mtimecmp;
    logic [1:0] sel;
    logic       wr_fire;
    word_t      rd_word;

    assign bus.req_ready = 1'b1;
    assign sel     = bus.req_addr[3:2];  // Word select inside the window.
    assign wr_fire = bus.req_valid && bus.req_wen;

    always_comb begin
        case (sel)
            2'd0:    rd_word = mtime[31:0];
            2'd1:    rd_word = mtime[63:32];
            2'd2:    rd_word = mtimecmp[31:0];
            default: rd_word = mtimecmp[63:32];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime     <= '0;
            mtimecmp  <= '1;  // Keeps the interrupt off.
            timer_irq <= 1'b0;
        end else begin
            mtime     <= mtime + 64'd1;
            timer_irq <= mtime >= mtimecmp;
            if (wr_fire) begin
                case (sel)
                    2'd0: mtime[31:0] <= apply_wmask(mtime[31:0], bus.req_wdata, bus.req_wmask);
                    2'd1: mtime[63:32] <= apply_wmask(mtime[63:32], bus.req_wdata,
                                                      bus.req_wmask);
                    2'd2: mtimecmp[31:0] <= apply_wmask(mtimecmp[31:0], bus.req_wdata,
                                                        bus.req_wmask);
                    default: mtimecmp[63:32] <= apply_wmask(mtimecmp[63:32], bus.req_wdata,
                                                            bus.req_wmask);
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) bus.resp_valid <= 1'b0;
        else bus.resp_valid <= bus.req_valid && !bus.req_wen;
    end

    always_ff @(posedge clk) bus.resp_rdata <= rd_word;

endmodule

`default_nettype wire

/* design/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module data_ram import mmio_pkg::*; (
    input  wire    clk,
    input  wire    rst_n,
    dbus_if.device bus
);

    localparam int AW = $clog2(`MMIO_RAM_WORDS);

    word_t         mem [`MMIO_RAM_WORDS];
    logic [AW-1:0] idx;
    logic          wr_fire;

    assign idx     = bus.req_addr[AW+1:2];  // Word address.
    assign wr_fire = bus.req_valid && bus.req_wen;

    assign bus.req_ready = 1'b1;

    always_ff @(posedge clk) begin
        for (int b = 0; b < `MMIO_XLEN / 8; b++) begin
            if (wr_fire && bus.req_wmask[b]) mem[idx][8*b +: 8] <= bus.req_wdata[8*b +: 8];
        end
        bus.resp_rdata <= mem[idx];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) bus.resp_valid <= 1'b0;
        else bus.resp_valid <= bus.req_valid && !bus.req_wen;
    end

endmodule

`default_nettype wire

/* design/mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmio_top import mmio_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         req_valid,
    output logic        req_ready,
    input  wire word_t  req_addr,
    input  wire         req_wen,
    input  wire word_t  req_wdata,
    input  wire wmask_t req_wmask,
    output logic        resp_valid,
    output word_t       resp_addr,
    output word_t       resp_rdata,
    input  wire         uart_rx,
    output logic        uart_tx,
    output logic        timer_irq
);

    dbus_if mem_bus ();
    dbus_if utx_bus ();
    dbus_if urx_bus ();
    dbus_if clint_bus ();

    mmio_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wen    (req_wen),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata),
        .mem_bus    (mem_bus),
        .utx_bus    (utx_bus),
        .urx_bus    (urx_bus),
        .clint_bus  (clint_bus)
    );

    data_ram    u_ram   (.clk(clk), .rst_n(rst_n), .bus(mem_bus));
    uart_tx_dev u_utx   (.clk(clk), .rst_n(rst_n), .bus(utx_bus), .uart_tx(uart_tx));
    uart_rx_dev u_urx   (.clk(clk), .rst_n(rst_n), .bus(urx_bus), .uart_rx(uart_rx));
    clint_dev   u_clint (.clk(clk), .rst_n(rst_n), .bus(clint_bus), .timer_irq(timer_irq));

endmodule

`default_nettype wire

/* tb/tb_mmio_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmio_defines.svh"

module tb_mmio_top import mmio_pkg::*; ();

    localparam int    cpb          = `MMIO_UART_CLKS_PER_BIT;
    localparam int    frame_cycles = 10 * cpb;
    localparam int    limit_cycles = 20000;  // A dozen frames plus the RAM loops, with margin.
    localparam int    rand_words   = 16;
    localparam word_t ram_base     = 32'h0000_0080;
    localparam word_t mtime_lo     = `MMIO_CLINT_BASE;
    localparam word_t mtimecmp_lo  = `MMIO_CLINT_BASE + 32'h8;
    localparam word_t mtimecmp_hi  = `MMIO_CLINT_BASE + 32'hC;

    logic   clk;
    logic   rst_n;
    logic   req_valid;
    logic   req_ready;
    word_t  req_addr;
    logic   req_wen;
    word_t  req_wdata;
    wmask_t req_wmask;
    logic   resp_valid;
    word_t  resp_addr;
    word_t  resp_rdata;
    logic   uart_rx;
    logic   uart_tx;
    logic   timer_irq;

    integer seed;
    word_t  ram_model [rand_words];

    mmio_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .req_wen    (req_wen),
        .req_wdata  (req_wdata),
        .req_wmask  (req_wmask),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_rdata (resp_rdata),
        .uart_rx    (uart_rx),
        .uart_tx    (uart_tx),
        .timer_irq  (timer_irq)
    );

    always #4 clk = ~clk;

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s expected 0x%08h, got 0x%08h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch at %0t: %s expected %b, got %b",
                                        $time, name, expected, actual));
        end
    endtask

    // Byte lanes with a set mask bit take the new data.
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, wmask_t mask);
        word_t take;
        take = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
        return (old_word & ~take) | (new_word & take);
    endfunction

    function automatic word_t fill_pattern(word_t addr);
        return (addr * 32'h0001_0001) ^ 32'h5A5A_A5A5;
    endfunction

    task automatic bus_write(input word_t addr, input word_t data, input wmask_t mask);
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_wen   = 1'b1;
        req_wdata = data;
        req_wmask = mask;
        while (req_ready !== 1'b1) @(negedge clk);  // Taken at the next rising edge.
        @(negedge clk);
        req_valid = 1'b0;
        req_wen   = 1'b0;
    endtask

    task automatic bus_read(input word_t addr, output word_t data);
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = addr;
        req_wen   = 1'b0;
        req_wmask = '0;
        while (req_ready !== 1'b1) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        while (resp_valid !== 1'b1) @(negedge clk);
        check_word("resp_addr", addr, resp_addr);
        data = resp_rdata;
    endtask

    task automatic uart_send_byte(input logic [7:0] data);
        @(negedge clk);
        uart_rx = 1'b0;
        repeat (cpb) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = data[i];  // LSB first.
            repeat (cpb) @(negedge clk);
        end
        uart_rx = 1'b1;
        repeat (cpb) @(negedge clk);
    endtask

    task automatic uart_recv_byte(output logic [7:0] data);
        @(negedge uart_tx);
        repeat (cpb / 2) @(negedge clk);  // Middle of the start bit.
        check_bit("uart_tx start bit", 1'b0, uart_tx);
        for (int i = 0; i < 8; i++) begin
            repeat (cpb) @(negedge clk);
            data[i] = uart_tx;
        end
        repeat (cpb) @(negedge clk);
        check_bit("uart_tx stop bit", 1'b1, uart_tx);
    endtask

    task automatic check_idle_outputs();
        check_bit("req_ready", 1'b1, req_ready);
        check_bit("resp_valid", 1'b0, resp_valid);
        check_bit("uart_tx", 1'b1, uart_tx);
        check_bit("timer_irq", 1'b0, timer_irq);
    endtask

    task automatic test_reset_state();
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        check_idle_outputs();
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_idle_outputs();
    endtask

    task automatic test_mem_masked_write();
        word_t rdata;
        bus_write(32'h0000_0040, 32'h1122_3344, 4'hF);
        bus_write(32'h0000_0040, 32'hAABB_CCDD, 4'b0100);
        bus_read(32'h0000_0040, rdata);
        check_word("ram merged word", 32'h11BB_3344, rdata);
    endtask

    task automatic test_uart_tx();
        logic [7:0] first;
        logic [7:0] second;
        word_t      status;
        fork
            begin
                uart_recv_byte(first);
                uart_recv_byte(second);
            end
            begin
                bus_write(`MMIO_ADDR_UART_TX, 32'h0000_00A5, 4'h1);
                bus_read(`MMIO_ADDR_UART_TX, status);
                check_word("uart tx status", 32'h0000_0001, status);
                bus_write(`MMIO_ADDR_UART_TX, 32'h0000_005A, 4'h1);
                check_bit("req_ready", 1'b0, req_ready);  // Second byte waits for the frame.
                while (req_ready !== 1'b1) @(negedge clk);
            end
        join
        check_word("uart_tx first byte", 32'h0000_00A5, word_t'(first));
        check_word("uart_tx second byte", 32'h0000_005A, word_t'(second));
    endtask

    task automatic test_uart_rx();
        word_t rdata;
        uart_send_byte(8'h3C);
        repeat (2 * frame_cycles) @(negedge clk);
        bus_read(`MMIO_ADDR_UART_RX, rdata);
        check_word("uart rx data", 32'h0000_013C, rdata);
        bus_read(`MMIO_ADDR_UART_RX, rdata);
        check_bit("uart rx full flag", 1'b0, rdata[8]);
    endtask

    task automatic test_timer();
        word_t t_first;
        word_t t_second;
        word_t readback;
        int    waited;
        bus_read(mtime_lo, t_first);
        bus_read(mtime_lo, t_second);
        check_bit("mtime increasing", 1'b1, t_second > t_first);
        bus_write(mtimecmp_lo, t_first + 32'd200, 4'hF);
        bus_write(mtimecmp_hi, 32'h0, 4'hF);
        check_bit("timer_irq", 1'b0, timer_irq);
        waited = 0;
        while (timer_irq !== 1'b1 && waited <= 210) begin
            @(negedge clk);
            waited++;
        end
        if (timer_irq !== 1'b1) begin
            stop_with_failure("timer_irq did not rise within 210 cycles of the mtimecmp write");
        end
        bus_read(mtime_lo, readback);
        check_bit("mtime past mtimecmp", 1'b1, readback >= t_first + 32'd200);
        bus_read(mtimecmp_lo, readback);
        check_word("mtimecmp low", t_first + 32'd200, readback);
        bus_read(mtimecmp_hi, readback);
        check_word("mtimecmp high", 32'h0, readback);
    endtask

    task automatic test_random_ram();
        word_t      addr;
        word_t      data;
        word_t      rdata;
        word_t      rnd;
        wmask_t     mask;
        logic [3:0] idx;
        for (int i = 0; i < rand_words; i++) begin
            addr = ram_base + 4 * i;
            ram_model[i] = fill_pattern(addr);
            bus_write(addr, ram_model[i], 4'hF);
        end
        repeat (64) begin
            rnd  = $random(seed);
            idx  = rnd[3:0];
            mask = rnd[7:4];
            data = $random(seed);
            bus_write(ram_base + {26'd0, idx, 2'b00}, data, mask);
            ram_model[idx] = merge_bytes(ram_model[idx], data, mask);
            rnd = $random(seed);
            idx = rnd[3:0];
            bus_read(ram_base + {26'd0, idx, 2'b00}, rdata);
            check_word("ram random read", ram_model[idx], rdata);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_wen   = 1'b0;
        req_wdata = '0;
        req_wmask = '0;
        uart_rx   = 1'b1;
        seed      = 32'h8a46;
        test_reset_state();
        test_mem_masked_write();
        test_uart_tx();
        test_uart_rx();
        test_timer();
        test_random_ram();
        $display("STATUS: PASS");
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        stop_with_failure("timeout: the tests did not finish within the cycle limit");
    end

endmodule

`default_nettype wire

/* mmio_bus.f */
+incdir+design
design/mmio_pkg.sv
design/dbus_if.sv
design/mmio_ctrl.sv
design/uart_tx_dev.sv
design/uart_rx_dev.sv
design/clint_dev.sv
design/data_ram.sv
design/mmio_top.sv
tb/tb_mmio_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mmio_top -f mmio_bus.f -o sim_mmio

./obj_dir/sim_mmio > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    exit 1
fi
